//--- common/wb_pkg.sv
/*
 * Wishbone subsystem definitions
 * Default bus widths, arbiter port count and arbitration mode codes
 */
package wb_pkg;

    // Arbiter size
    localparam int WB_PORTS = 3;                // Masters sharing the slave

    // Bus width defaults
    localparam int WB_DATA_W_DEF = 32;          // Data bus in bits
    localparam int WB_ADDR_W_DEF = 32;          // Byte address in bits
    localparam int WB_RAM_AW_DEF = 6;           // RAM word address, 64 words

    // Arbitration scheme
    localparam bit ARB_FIXED = 1'b0;            // Fixed priority
    localparam bit ARB_RR    = 1'b1;            // Round robin

    // Priority direction
    localparam bit ARB_MSB_FIRST = 1'b0;        // Highest index wins
    localparam bit ARB_LSB_FIRST = 1'b1;        // Index 0 wins

endpackage

//--- common/wb_bus_if.sv
/*
 * Wishbone classic link
 * One master to one slave, no bursts, err or retry
 */
`timescale 1ns/1ps

interface wb_bus_if #(
    parameter int DATA_W = wb_pkg::WB_DATA_W_DEF,  // Data width in bits
    parameter int ADDR_W = wb_pkg::WB_ADDR_W_DEF   // Byte address width
);

    localparam int SEL_W = DATA_W / 8;              // One select bit per byte lane

    logic [ADDR_W-1:0] adr;                         // Byte address
    logic [DATA_W-1:0] dat_m2s;                     // Write data
    logic [DATA_W-1:0] dat_s2m;                     // Read data
    logic              we;                          // Write enable
    logic [SEL_W-1:0]  sel;                         // Byte lane select
    logic              stb;                         // Strobe, access valid
    logic              ack;                         // Access done
    logic              cyc;                         // Bus cycle in progress

    // Drives the request side
    modport master (
        output adr, dat_m2s, we, sel, stb, cyc,
        input  dat_s2m, ack
    );

    // Answers the request
    modport slave (
        input  adr, dat_m2s, we, sel, stb, cyc,
        output dat_s2m, ack
    );

endinterface

//--- arbiter/wb_grant_arbiter.sv
/*
 * Request/grant arbiter with blocking grant
 * Fixed priority or round robin, either index direction first
 */
`timescale 1ns/1ps

module wb_grant_arbiter #(
    parameter bit ROUND_ROBIN       = wb_pkg::ARB_FIXED,     // Round robin instead of fixed
    parameter bit LSB_HIGH_PRIORITY = wb_pkg::ARB_MSB_FIRST  // Index 0 first instead of top
) (
    input  logic                        clk,
    input  logic                        rst_i,
    input  logic [wb_pkg::WB_PORTS-1:0] request_i,       // One bit per master
    output logic [wb_pkg::WB_PORTS-1:0] grant_o,         // One-hot
    output logic                        grant_valid_o,
    output logic [1:0]                  grant_idx_o      // Encoded grant
);
    import wb_pkg::*;

    localparam bit USE_RR    = (ROUND_ROBIN == ARB_RR);
    localparam bit LSB_FIRST = (LSB_HIGH_PRIORITY == ARB_LSB_FIRST);
    // Round robin pointer starts one before the first index searched
    localparam logic [1:0] IDX_INIT = LSB_FIRST ? 2'(WB_PORTS - 1) : 2'd0;

    logic [WB_PORTS-1:0] grant_q;
    logic [WB_PORTS-1:0] grant_d;
    logic                grant_valid_q;
    logic                grant_valid_d;
    logic [1:0]          grant_idx_q;                    // Also the last granted index
    logic [1:0]          grant_idx_d;
    logic [WB_PORTS-1:0] rr_mask;                        // Indices after the last winner
    logic [WB_PORTS-1:0] masked_req;
    logic [1:0]          pick_idx;                       // Winner of this cycle's search

    // First set bit in priority order
    function automatic logic [1:0] first_set(input logic [WB_PORTS-1:0] vec);
        logic [1:0] idx;
        idx = 2'd0;
        for (int i = 0; i < WB_PORTS; i++) begin
            if (LSB_FIRST) begin
                if (vec[WB_PORTS-1-i])
                    idx = 2'(WB_PORTS - 1 - i);           // Lowest set bit lands last
            end else if (vec[i]) begin
                idx = 2'(i);                              // Highest set bit lands last
            end
        end
        return idx;
    endfunction

    always_comb begin
        for (int i = 0; i < WB_PORTS; i++) begin
            if (!USE_RR)
                rr_mask[i] = 1'b1;                        // Fixed priority searches everything
            else if (LSB_FIRST)
                rr_mask[i] = (i > int'(grant_idx_q));
            else
                rr_mask[i] = (i < int'(grant_idx_q));
        end
    end

    assign masked_req = request_i & rr_mask;
    assign pick_idx   = (|masked_req) ? first_set(masked_req) : first_set(request_i); // Wrap

    always_comb begin
        grant_d       = grant_q;
        grant_valid_d = grant_valid_q;
        grant_idx_d   = grant_idx_q;
        if (grant_valid_q) begin
            if (!request_i[grant_idx_q]) begin
                grant_d       = '0;                       // Owner let go, idle one cycle
                grant_valid_d = 1'b0;
            end
        end else if (|request_i) begin
            grant_d           = '0;
            grant_d[pick_idx] = 1'b1;
            grant_valid_d     = 1'b1;
            grant_idx_d       = pick_idx;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            grant_q       <= '0;
            grant_valid_q <= 1'b0;
            grant_idx_q   <= IDX_INIT;
        end else begin
            grant_q       <= grant_d;
            grant_valid_q <= grant_valid_d;
            grant_idx_q   <= grant_idx_d;
        end
    end

    assign grant_o       = grant_q;
    assign grant_valid_o = grant_valid_q;
    assign grant_idx_o   = grant_idx_q;

endmodule

//--- arbiter/wb_arbiter3.sv
/*
 * Three master Wishbone arbiter
 * Grants the slave bus on cyc and holds it until the owner drops cyc
 */
`timescale 1ns/1ps

module wb_arbiter3 #(
    parameter int DATA_W            = wb_pkg::WB_DATA_W_DEF,
    parameter int ADDR_W            = wb_pkg::WB_ADDR_W_DEF,
    parameter bit ROUND_ROBIN       = wb_pkg::ARB_FIXED,
    parameter bit LSB_HIGH_PRIORITY = wb_pkg::ARB_MSB_FIRST
) (
    input logic     clk,
    input logic     rst_i,
    wb_bus_if.slave  m0,                                 // Master 0 side
    wb_bus_if.slave  m1,                                 // Master 1 side
    wb_bus_if.slave  m2,                                 // Master 2 side
    wb_bus_if.master s                                   // Toward the slave
);
    import wb_pkg::*;

    localparam int SEL_W = DATA_W / 8;

    logic [WB_PORTS-1:0] request;
    logic [WB_PORTS-1:0] grant;
    logic                grant_valid;
    logic [1:0]          grant_idx;
    logic [WB_PORTS-1:0] owner;                          // Grant qualified by valid

    assign request = {m2.cyc, m1.cyc, m0.cyc};           // cyc is the bus request
    assign owner   = grant & {WB_PORTS{grant_valid}};

    wb_grant_arbiter #(
        .ROUND_ROBIN       (ROUND_ROBIN),
        .LSB_HIGH_PRIORITY (LSB_HIGH_PRIORITY)
    ) u_grant (
        .clk           (clk),
        .rst_i         (rst_i),
        .request_i     (request),
        .grant_o       (grant),
        .grant_valid_o (grant_valid),
        .grant_idx_o   (grant_idx)
    );

    // Slave side mux, all zero without a grant
    always_comb begin
        s.adr     = {ADDR_W{1'b0}};
        s.dat_m2s = {DATA_W{1'b0}};
        s.we      = 1'b0;
        s.sel     = {SEL_W{1'b0}};
        s.stb     = 1'b0;
        s.cyc     = grant_valid;                         // Owner keeps the cycle open
        if (grant_valid) begin
            case (grant_idx)
                2'd0: begin
                    s.adr     = m0.adr;
                    s.dat_m2s = m0.dat_m2s;
                    s.we      = m0.we;
                    s.sel     = m0.sel;
                    s.stb     = m0.stb;
                end
                2'd1: begin
                    s.adr     = m1.adr;
                    s.dat_m2s = m1.dat_m2s;
                    s.we      = m1.we;
                    s.sel     = m1.sel;
                    s.stb     = m1.stb;
                end
                2'd2: begin
                    s.adr     = m2.adr;
                    s.dat_m2s = m2.dat_m2s;
                    s.we      = m2.we;
                    s.sel     = m2.sel;
                    s.stb     = m2.stb;
                end
                default: begin
                    s.stb     = 1'b0;                    // Unused code, no access
                end
            endcase
        end
    end

    // Read data to everyone, ack only to the owner
    assign m0.dat_s2m = s.dat_s2m;
    assign m1.dat_s2m = s.dat_s2m;
    assign m2.dat_s2m = s.dat_s2m;

    assign m0.ack = s.ack & owner[0];
    assign m1.ack = s.ack & owner[1];
    assign m2.ack = s.ack & owner[2];

endmodule

//--- hdl/wb_ram.sv
/*
 * Wishbone slave RAM
 * Byte lane writes, registered read data, one cycle ack
 */
`timescale 1ns/1ps

module wb_ram #(
    parameter int DATA_W = wb_pkg::WB_DATA_W_DEF,
    parameter int ADDR_W = wb_pkg::WB_ADDR_W_DEF,
    parameter int RAM_AW = wb_pkg::WB_RAM_AW_DEF          // Depth is 2**RAM_AW words
) (
    input logic     clk,
    input logic     rst_i,
    wb_bus_if.slave s
);

    localparam int SEL_W = DATA_W / 8;
    localparam int OFS_W = $clog2(SEL_W);                 // Byte offset bits in the address
    localparam int DEPTH = 1 << RAM_AW;

    logic [DATA_W-1:0] mem [DEPTH];
    logic [ADDR_W-1:0] byte_adr;
    logic [RAM_AW-1:0] word_adr;
    logic              access;                            // New access this cycle
    logic              ack_q;
    logic [DATA_W-1:0] rdata_q;

    assign byte_adr = s.adr;
    assign word_adr = byte_adr[OFS_W +: RAM_AW];          // Upper address bits wrap
    // Ack low guards against answering the same strobe twice
    assign access   = s.cyc & s.stb & ~ack_q;

    // Storage and read port
    always_ff @(posedge clk) begin
        if (access) begin
            rdata_q <= mem[word_adr];                     // Old data on a write
            if (s.we) begin
                for (int b = 0; b < SEL_W; b++) begin
                    if (s.sel[b])
                        mem[word_adr][8*b +: 8] <= s.dat_m2s[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i)
            ack_q <= 1'b0;
        else
            ack_q <= access;                              // Single pulse per access
    end

    assign s.ack     = ack_q;
    assign s.dat_s2m = rdata_q;                           // Valid with ack

endmodule

//--- hdl/wb_arb_ram_top.sv
/*
 * Shared memory subsystem
 * Three Wishbone masters reach one RAM through the arbiter
 */
`timescale 1ns/1ps

module wb_arb_ram_top #(
    parameter int DATA_W            = wb_pkg::WB_DATA_W_DEF,
    parameter int ADDR_W            = wb_pkg::WB_ADDR_W_DEF,
    parameter bit ROUND_ROBIN       = wb_pkg::ARB_FIXED,
    parameter bit LSB_HIGH_PRIORITY = wb_pkg::ARB_MSB_FIRST,
    parameter int RAM_AW            = wb_pkg::WB_RAM_AW_DEF
) (
    input  logic                  clk,
    input  logic                  rst_i,

    input  logic [ADDR_W-1:0]     wbm0_adr_i,             // Master 0
    input  logic [DATA_W-1:0]     wbm0_dat_i,
    output logic [DATA_W-1:0]     wbm0_dat_o,
    input  logic                  wbm0_we_i,
    input  logic [DATA_W/8-1:0]   wbm0_sel_i,
    input  logic                  wbm0_stb_i,
    output logic                  wbm0_ack_o,
    input  logic                  wbm0_cyc_i,

    input  logic [ADDR_W-1:0]     wbm1_adr_i,             // Master 1
    input  logic [DATA_W-1:0]     wbm1_dat_i,
    output logic [DATA_W-1:0]     wbm1_dat_o,
    input  logic                  wbm1_we_i,
    input  logic [DATA_W/8-1:0]   wbm1_sel_i,
    input  logic                  wbm1_stb_i,
    output logic                  wbm1_ack_o,
    input  logic                  wbm1_cyc_i,

    input  logic [ADDR_W-1:0]     wbm2_adr_i,             // Master 2
    input  logic [DATA_W-1:0]     wbm2_dat_i,
    output logic [DATA_W-1:0]     wbm2_dat_o,
    input  logic                  wbm2_we_i,
    input  logic [DATA_W/8-1:0]   wbm2_sel_i,
    input  logic                  wbm2_stb_i,
    output logic                  wbm2_ack_o,
    input  logic                  wbm2_cyc_i
);

    wb_bus_if #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) m0_bus ();
    wb_bus_if #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) m1_bus ();
    wb_bus_if #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) m2_bus ();
    wb_bus_if #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) ram_bus ();  // Arbiter to RAM

    // Master 0 pins onto its link
    assign m0_bus.adr     = wbm0_adr_i;
    assign m0_bus.dat_m2s = wbm0_dat_i;
    assign m0_bus.we      = wbm0_we_i;
    assign m0_bus.sel     = wbm0_sel_i;
    assign m0_bus.stb     = wbm0_stb_i;
    assign m0_bus.cyc     = wbm0_cyc_i;
    assign wbm0_dat_o     = m0_bus.dat_s2m;
    assign wbm0_ack_o     = m0_bus.ack;

    // Master 1
    assign m1_bus.adr     = wbm1_adr_i;
    assign m1_bus.dat_m2s = wbm1_dat_i;
    assign m1_bus.we      = wbm1_we_i;
    assign m1_bus.sel     = wbm1_sel_i;
    assign m1_bus.stb     = wbm1_stb_i;
    assign m1_bus.cyc     = wbm1_cyc_i;
    assign wbm1_dat_o     = m1_bus.dat_s2m;
    assign wbm1_ack_o     = m1_bus.ack;

    // Master 2
    assign m2_bus.adr     = wbm2_adr_i;
    assign m2_bus.dat_m2s = wbm2_dat_i;
    assign m2_bus.we      = wbm2_we_i;
    assign m2_bus.sel     = wbm2_sel_i;
    assign m2_bus.stb     = wbm2_stb_i;
    assign m2_bus.cyc     = wbm2_cyc_i;
    assign wbm2_dat_o     = m2_bus.dat_s2m;
    assign wbm2_ack_o     = m2_bus.ack;

    wb_arbiter3 #(
        .DATA_W            (DATA_W),
        .ADDR_W            (ADDR_W),
        .ROUND_ROBIN       (ROUND_ROBIN),
        .LSB_HIGH_PRIORITY (LSB_HIGH_PRIORITY)
    ) u_arb (
        .clk   (clk),
        .rst_i (rst_i),
        .m0    (m0_bus.slave),
        .m1    (m1_bus.slave),
        .m2    (m2_bus.slave),
        .s     (ram_bus.master)
    );

    wb_ram #(
        .DATA_W (DATA_W),
        .ADDR_W (ADDR_W),
        .RAM_AW (RAM_AW)
    ) u_ram (
        .clk   (clk),
        .rst_i (rst_i),
        .s     (ram_bus.slave)
    );

endmodule

//--- dv/tb_wb_arb.sv
/*
 * Testbench for the shared memory subsystem
 * Replays the stim file against an arbitration model and a memory model
 */
`timescale 1ns/1ps

module tb_wb_arb #(
    parameter bit ROUND_ROBIN       = 1'b1,
    parameter bit LSB_HIGH_PRIORITY = 1'b1
);
    import wb_pkg::*;

    localparam int MAX_LINES   = 64;
    localparam int ACK_TIMEOUT = 50;                      // Cycles allowed per ack wait

    logic        clk = 1'b0;
    logic        rst_i;
    logic [31:0] m_adr [3];                               // Per master request side
    logic [31:0] m_dat [3];
    logic [3:0]  m_sel [3];
    logic [2:0]  m_we;
    logic [2:0]  m_stb;
    logic [2:0]  m_cyc;
    wire  [31:0] rdat [3];
    wire  [2:0]  acks;

    int          n_lines;                                 // Transactions loaded
    int          t_grp [MAX_LINES];
    int          t_m   [MAX_LINES];
    bit          t_hold[MAX_LINES];
    bit          t_we  [MAX_LINES];
    logic [31:0] t_adr [MAX_LINES];
    logic [31:0] t_dat [MAX_LINES];
    logic [3:0]  t_sel [MAX_LINES];
    logic [31:0] model_mem [1 << WB_RAM_AW_DEF];           // Expected RAM contents
    int          last_idx;                                // Last granted master
    int unsigned seed_out;

    always #2 clk = ~clk;                                 // 4 ns period

    wb_arb_ram_top #(
        .ROUND_ROBIN       (ROUND_ROBIN),
        .LSB_HIGH_PRIORITY (LSB_HIGH_PRIORITY)
    ) u_dut (
        .clk (clk), .rst_i (rst_i),
        .wbm0_adr_i (m_adr[0]), .wbm0_dat_i (m_dat[0]), .wbm0_dat_o (rdat[0]),
        .wbm0_we_i (m_we[0]), .wbm0_sel_i (m_sel[0]), .wbm0_stb_i (m_stb[0]),
        .wbm0_ack_o (acks[0]), .wbm0_cyc_i (m_cyc[0]),
        .wbm1_adr_i (m_adr[1]), .wbm1_dat_i (m_dat[1]), .wbm1_dat_o (rdat[1]),
        .wbm1_we_i (m_we[1]), .wbm1_sel_i (m_sel[1]), .wbm1_stb_i (m_stb[1]),
        .wbm1_ack_o (acks[1]), .wbm1_cyc_i (m_cyc[1]),
        .wbm2_adr_i (m_adr[2]), .wbm2_dat_i (m_dat[2]), .wbm2_dat_o (rdat[2]),
        .wbm2_we_i (m_we[2]), .wbm2_sel_i (m_sel[2]), .wbm2_stb_i (m_stb[2]),
        .wbm2_ack_o (acks[2]), .wbm2_cyc_i (m_cyc[2])
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_val(input string name, input logic [31:0] act, input logic [31:0] exp);
        if (act !== exp) begin
            $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, act, exp);
            abort_run($sformatf("%s mismatch at %0t", name, $time));
        end
    endtask

    task automatic load_stim();
        int fd;
        int code;
        int g, m, h, w;
        logic [31:0] a, d, s;
        logic [8*160-1:0] text;
        n_lines = 0;
        fd = $fopen("dv/wb_arb_stim.txt", "r");
        if (fd == 0) begin
            abort_run("could not open the stimulus file dv/wb_arb_stim.txt");
        end else begin
            while (!$feof(fd) && n_lines < MAX_LINES) begin
                text = '0;
                code = $fgets(text, fd);
                code = $sscanf(text, "%d %d %d %d %h %h %h", g, m, h, w, a, d, s);
                if (code == 7) begin                      // Comment lines do not parse
                    t_grp[n_lines]  = g;
                    t_m[n_lines]    = m;
                    t_hold[n_lines] = (h != 0);
                    t_we[n_lines]   = (w != 0);
                    t_adr[n_lines]  = a;
                    t_dat[n_lines]  = (d == 32'h0) ? $urandom() : d;  // Zero asks for random
                    t_sel[n_lines]  = s[3:0];
                    n_lines++;
                end
            end
            $fclose(fd);
        end
    endtask

    // Rotating search from the last winner, fixed priority never moves it
    function automatic int pick_winner(input logic [2:0] pend, input int last);
        int idx;
        for (int k = 1; k <= 3; k++) begin
            idx = LSB_HIGH_PRIORITY ? (last + k) % 3 : (last + 3 - k) % 3;
            if (pend[idx])
                return idx;
        end
        return -1;
    endfunction

    // Next line of master m after line from, inside the group ending at last
    function automatic int next_line(input int m, input int from, input int last);
        for (int i = from + 1; i <= last; i++) begin
            if (t_m[i] == m)
                return i;
        end
        return -1;
    endfunction

    task automatic drive_line(input int i);
        m_adr[t_m[i]] = t_adr[i];
        m_dat[t_m[i]] = t_dat[i];
        m_sel[t_m[i]] = t_sel[i];
        m_we[t_m[i]]  = t_we[i];
        m_stb[t_m[i]] = 1'b1;
        m_cyc[t_m[i]] = 1'b1;
    endtask

    task automatic release_master(input int m);
        m_stb[m] = 1'b0;
        m_cyc[m] = 1'b0;
        m_we[m]  = 1'b0;
    endtask

    // Compare read data or apply a write to the model
    task automatic finish_access(input int i);
        logic [WB_RAM_AW_DEF-1:0] wi;
        wi = t_adr[i][2 +: WB_RAM_AW_DEF];
        if (t_we[i]) begin
            for (int b = 0; b < 4; b++) begin
                if (t_sel[i][b])
                    model_mem[wi][8*b +: 8] = t_dat[i][8*b +: 8];
            end
        end else begin
            check_val($sformatf("wbm%0d_dat_o", t_m[i]), rdat[t_m[i]], model_mem[wi]);
        end
    endtask

    task automatic run_group(input int first, input int last);
        int exp_q[$];                                     // Expected ack order, line indices
        int cur [3];
        logic [2:0] pend;
        int w, i, n, idle, nxt;
        pend = 3'b000;
        for (int m = 0; m < 3; m++) begin
            cur[m] = next_line(m, first - 1, last);
            if (cur[m] >= 0)
                pend[m] = 1'b1;
        end
        while (pend != 3'b000) begin                      // Owner keeps the bus for its whole chain
            w = pick_winner(pend, last_idx);
            if (ROUND_ROBIN)
                last_idx = w;
            for (i = cur[w]; i >= 0; i = next_line(w, i, last))
                exp_q.push_back(i);
            pend[w] = 1'b0;
        end
        @(negedge clk);
        for (int m = 0; m < 3; m++) begin
            if (cur[m] >= 0)
                drive_line(cur[m]);                       // Whole group starts together
        end
        n = 0;
        idle = 0;
        while (n < exp_q.size()) begin
            @(negedge clk);
            if (acks != 3'b000) begin
                i = exp_q[n];
                check_val("wbm_ack_o", 32'(acks), 32'(1) << t_m[i]);
                finish_access(i);
                nxt = next_line(t_m[i], i, last);
                if (t_hold[i] != (nxt >= 0))
                    abort_run($sformatf("hold flag of stim line %0d does not match its group", i));
                else if (t_hold[i])
                    drive_line(nxt);                      // cyc stays up
                else
                    release_master(t_m[i]);
                n++;
                idle = 0;
            end else begin
                idle++;
                if (idle >= ACK_TIMEOUT)
                    abort_run($sformatf("no ack within %0d cycles in group %0d",
                                        ACK_TIMEOUT, t_grp[first]));
            end
        end
    endtask

    initial begin
        int first;
        int last;
        seed_out = $urandom(32'hc384_f598);
        rst_i    = 1'b1;
        m_we     = 3'b000;
        m_stb    = 3'b000;
        m_cyc    = 3'b000;
        for (int m = 0; m < 3; m++) begin
            m_adr[m] = '0;
            m_dat[m] = '0;
            m_sel[m] = '0;
        end
        last_idx = LSB_HIGH_PRIORITY ? 2 : 0;            // One before the first searched
        load_stim();
        if (n_lines == 0)
            abort_run("the stimulus file holds no transactions");
        repeat (3) @(negedge clk);
        rst_i = 1'b0;
        repeat (3) begin
            @(negedge clk);
            check_val("wbm_ack_o", 32'(acks), 32'h0);     // Quiet before any request
        end
        first = 0;
        while (first < n_lines) begin
            last = first;
            while (last + 1 < n_lines && t_grp[last + 1] == t_grp[first])
                last++;
            run_group(first, last);
            repeat (2) begin
                @(negedge clk);
                check_val("wbm_ack_o", 32'(acks), 32'h0);
            end
            first = last + 1;
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule

//--- dv/wb_arb_stim.txt
# grp master hold we adr(hex) dat(hex, 0 means random) sel(hex)
# Lines of one group start at the same edge, hold keeps cyc up into the next line
# Single master, full write, partial write, read back
1  0 0 1 00000000 11223344 f
2  0 0 1 00000000 aabbccdd 5
3  0 0 0 00000000 00000000 0
4  1 0 1 00000004 00000000 f
5  2 0 1 00000008 00000000 f
6  1 0 0 00000004 00000000 0
# Three way contention, repeated to rotate the winner
7  0 0 1 00000010 00000000 f
7  1 0 1 00000014 00000000 f
7  2 0 1 00000018 00000000 f
8  0 0 0 00000014 00000000 0
8  1 0 0 00000018 00000000 0
8  2 0 0 00000010 00000000 0
9  0 0 0 00000018 00000000 0
9  1 0 0 00000010 00000000 0
9  2 0 0 00000014 00000000 0
10 0 0 0 00000010 00000000 0
10 1 0 0 00000014 00000000 0
10 2 0 0 00000018 00000000 0
# Two masters, partial writes then cross reads
11 0 0 1 00000004 00000000 3
11 2 0 1 00000008 00000000 c
12 0 0 0 00000008 00000000 0
12 2 0 0 00000004 00000000 0
# Held masters keep the grant across their chain
13 0 1 1 00000020 00000000 f
13 0 0 0 00000020 00000000 0
13 1 0 0 00000004 00000000 0
13 2 0 0 00000008 00000000 0
14 2 1 1 00000024 00000000 f
14 2 1 1 00000024 00000000 2
14 2 0 0 00000024 00000000 0
14 0 0 0 00000010 00000000 0
14 1 0 0 00000014 00000000 0
15 1 1 0 00000018 00000000 0
15 1 0 1 00000018 00000000 9
15 0 0 0 00000000 00000000 0
15 2 0 0 00000018 00000000 0
16 1 0 0 00000018 00000000 0
16 0 0 0 00000020 00000000 0
16 2 0 0 00000024 00000000 0

//--- vlog.f
common/wb_pkg.sv
common/wb_bus_if.sv
arbiter/wb_grant_arbiter.sv
arbiter/wb_arbiter3.sv
hdl/wb_ram.sv
hdl/wb_arb_ram_top.sv
dv/tb_wb_arb.sv

//--- Makefile
# Verilator build of the shared memory testbench in two arbiter configurations
#   rr_lsb    round robin, index 0 first
#   fixed_msb fixed priority, index 2 first

SRCS := $(shell cat vlog.f)

.PHONY: all run check clean

all: run

# The stem selects the arbitration mode and the priority direction
build/%/Vtb_wb_arb: $(SRCS) vlog.f
	verilator --binary --timing -f vlog.f --top-module tb_wb_arb \
	    -GROUND_ROBIN=$(if $(findstring rr,$*),1,0) \
	    -GLSB_HIGH_PRIORITY=$(if $(findstring lsb,$*),1,0) \
	    -Mdir build/$* -o Vtb_wb_arb

run: build/rr_lsb/Vtb_wb_arb build/fixed_msb/Vtb_wb_arb
	-./build/rr_lsb/Vtb_wb_arb > build/rr_lsb.log 2>&1
	-./build/fixed_msb/Vtb_wb_arb > build/fixed_msb.log 2>&1
	@$(MAKE) --no-print-directory check

check:
	grep -q "TESTS PASSED" build/rr_lsb.log
	grep -q "TESTS PASSED" build/fixed_msb.log

clean:
	rm -rf build
